// ==== source/conv_pkg.sv ====
package conv_pkg;

    // ######################################
    // Datapath widths
    // ######################################

    // Window samples and kernel weights share one width.
    localparam int SAMPLE_WIDTH = 16;

    // Products and the running sum wrap at this width.
    localparam int ACC_WIDTH = 32;

    // ######################################
    // Datapath types
    // ######################################

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // One reduced window leaving the adder tree.
    typedef struct packed {
        logic valid;
        acc_t sum;
    } conv_result_t;

endpackage

// ==== source/apb_pkg.sv ====
package apb_pkg;

    // ######################################
    // Bus widths
    // ######################################

    localparam int APB_ADDR_WIDTH = 12;

    localparam int APB_DATA_WIDTH = 32;

    // ######################################
    // Bus signals
    // ######################################

    // Everything the requester drives.
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    // Everything the completer returns.
    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // ######################################
    // Register map
    // ######################################

    // Weight i lives at WEIGHT_BASE + 4*i, one 32-bit word per tap.
    localparam logic [APB_ADDR_WIDTH-1:0] WEIGHT_BASE = '0;

endpackage

// ==== source/conv_weight_regs.sv ====
`timescale 1ns/1ps

module conv_weight_regs #(
    parameter int TAPS = 25
)
(
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output conv_pkg::sample_t weights [TAPS]
);

    import apb_pkg::*;
    import conv_pkg::*;

    localparam int IDX_WIDTH = (TAPS > 1) ? $clog2(TAPS) : 1;

    logic                      access;
    logic [APB_ADDR_WIDTH-1:0] offset;
    logic                      addr_ok;
    logic [IDX_WIDTH-1:0]      weight_idx;
    logic [APB_DATA_WIDTH-1:0] read_data;

    // ######################################
    // Address decode
    // ######################################

    // pready is tied high, so the access cycle is always the last cycle of a transfer.
    assign access = apb_req.psel && apb_req.penable;

    assign offset = apb_req.paddr - WEIGHT_BASE;

    // Only whole words inside the weight bank are legal.
    assign addr_ok = (offset[1:0] == 2'b00) &&
                     (offset < APB_ADDR_WIDTH'(4 * TAPS));

    assign weight_idx = offset[IDX_WIDTH+1:2];

    // ######################################
    // Weight bank
    // ######################################

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < TAPS; i++)
            begin
                weights[i] <= '0;
            end
        end
        else if (access && apb_req.pwrite && addr_ok)
        begin
            // Upper half of the write data is ignored.
            weights[weight_idx] <= apb_req.pwdata[SAMPLE_WIDTH-1:0];
        end
    end

    // ######################################
    // Readback
    // ######################################

    always_comb
    begin
        read_data = '0;
        if (access && !apb_req.pwrite && addr_ok)
        begin
            // The weight is signed, so the widening cast sign-extends it.
            read_data = APB_DATA_WIDTH'(weights[weight_idx]);
        end
    end

    // Bad addresses error in the access cycle and read back as zero.
    assign apb_rsp = '{
        prdata:  read_data,
        pready:  1'b1,
        pslverr: access && !addr_ok
    };

endmodule

// ==== source/conv_product_stage.sv ====
`timescale 1ns/1ps

module conv_product_stage #(
    parameter int TAPS = 25
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              window_valid,
    input  conv_pkg::sample_t window [TAPS],
    input  conv_pkg::sample_t weights [TAPS],
    output logic              product_valid,
    output conv_pkg::acc_t    products [TAPS]
);

    import conv_pkg::*;

    acc_t mul_out [TAPS];

    // ######################################
    // Multipliers
    // ######################################

    // Operands are widened first, so the full signed 16x16 product fits in ACC_WIDTH.
    always_comb
    begin
        for (int i = 0; i < TAPS; i++)
        begin
            mul_out[i] = acc_t'(window[i]) * acc_t'(weights[i]);
        end
    end

    // ######################################
    // Product register
    // ######################################

    // Weights are sampled at the capture edge itself.
    // A write completing on that edge only reaches the next window.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            product_valid <= 1'b0;
            for (int i = 0; i < TAPS; i++)
            begin
                products[i] <= '0;
            end
        end
        else
        begin
            product_valid <= window_valid;
            // Products hold their last value through idle cycles.
            if (window_valid)
            begin
                for (int i = 0; i < TAPS; i++)
                begin
                    products[i] <= mul_out[i];
                end
            end
        end
    end

endmodule

// ==== source/conv_adder_tree.sv ====
`timescale 1ns/1ps

module conv_adder_tree #(
    parameter int TAPS = 25
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   product_valid,
    input  conv_pkg::acc_t         products [TAPS],
    output conv_pkg::conv_result_t result
);

    import conv_pkg::*;

    // One registered level per halving, down to a single term.
    localparam int LEVELS = $clog2(TAPS);

    logic [LEVELS-1:0] valid_q;

    // Number of terms entering the given level of the tree.
    function automatic int level_count(input int depth);
        int count;
        count = TAPS;
        for (int i = 0; i < depth; i++)
        begin
            count = (count + 1) / 2;
        end
        return count;
    endfunction

    // ######################################
    // Reduction levels
    // ######################################

    for (genvar l = 0; l < LEVELS; l++)
    begin : tree_level
        localparam int IN_CNT  = level_count(l);
        localparam int OUT_CNT = level_count(l + 1);

        acc_t in_term [IN_CNT];
        acc_t sum_q [OUT_CNT];

        if (l == 0)
        begin : first_input
            assign in_term = products;
        end
        else
        begin : chained_input
            assign in_term = tree_level[l - 1].sum_q;
        end

        always_ff @(posedge clk or posedge reset)
        begin
            if (reset)
            begin
                for (int j = 0; j < OUT_CNT; j++)
                begin
                    sum_q[j] <= '0;
                end
            end
            else
            begin
                // Sums wrap at ACC_WIDTH, same as the integer model.
                for (int j = 0; j < IN_CNT / 2; j++)
                begin
                    sum_q[j] <= in_term[2 * j] + in_term[2 * j + 1];
                end
                // An odd leftover term is registered unchanged to stay aligned.
                if (IN_CNT % 2 == 1)
                begin
                    sum_q[OUT_CNT - 1] <= in_term[IN_CNT - 1];
                end
            end
        end
    end

    // ######################################
    // Valid pipeline
    // ######################################

    // Runs beside the sums, one bit per level.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q[0] <= product_valid;
            for (int i = 1; i < LEVELS; i++)
            begin
                valid_q[i] <= valid_q[i - 1];
            end
        end
    end

    assign result = '{
        valid: valid_q[LEVELS - 1],
        sum:   tree_level[LEVELS - 1].sum_q[0]
    };

endmodule

// ==== source/conv_window_engine.sv ====
`timescale 1ns/1ps

module conv_window_engine #(
    parameter int  KERNEL_SIZE = 5,
    localparam int TAPS        = KERNEL_SIZE * KERNEL_SIZE
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  apb_pkg::apb_req_t      apb_req,
    output apb_pkg::apb_rsp_t      apb_rsp,
    input  logic                   window_valid,
    input  conv_pkg::sample_t      window [TAPS],
    output conv_pkg::conv_result_t result
);

    import conv_pkg::*;

    sample_t weights [TAPS];
    logic    product_valid;
    acc_t    products [TAPS];

    // ######################################
    // Kernel weights over APB
    // ######################################

    conv_weight_regs #(
        .TAPS (TAPS)
    ) u_weight_regs (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .weights (weights)
    );

    // ######################################
    // Datapath
    // ######################################

    // One cycle for the multipliers, then one cycle per tree level.
    conv_product_stage #(
        .TAPS (TAPS)
    ) u_product_stage (
        .clk           (clk),
        .reset         (reset),
        .window_valid  (window_valid),
        .window        (window),
        .weights       (weights),
        .product_valid (product_valid),
        .products      (products)
    );

    conv_adder_tree #(
        .TAPS (TAPS)
    ) u_adder_tree (
        .clk           (clk),
        .reset         (reset),
        .product_valid (product_valid),
        .products      (products),
        .result        (result)
    );

endmodule

// ==== test/conv_result_checker.sv ====
`timescale 1ns/1ps

module conv_result_checker #(
    parameter int TAPS = 25
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  apb_pkg::apb_req_t      apb_req,
    input  apb_pkg::apb_rsp_t      apb_rsp,
    input  logic                   window_valid,
    input  conv_pkg::sample_t      window [TAPS],
    input  conv_pkg::conv_result_t result,
    output int                     error_count,
    output int                     results_checked
);

    import apb_pkg::*;
    import conv_pkg::*;

    // Rising edges from a window being presented to its sum being visible.
    // The capture edge counts, then one edge per tree level.
    localparam int LATENCY = 1 + $clog2(TAPS);

    typedef struct packed {
        int   due;
        acc_t sum;
    } expected_t;

    sample_t   model_weights [TAPS];
    expected_t pending [$];
    int        cycle;

    // ######################################
    // Reference rules
    // ######################################

    function automatic logic addr_legal(input logic [APB_ADDR_WIDTH-1:0] addr);
        int offset;
        offset = int'(addr - WEIGHT_BASE);
        return (offset % 4 == 0) && (offset < 4 * TAPS);
    endfunction

    function automatic int tap_index(input logic [APB_ADDR_WIDTH-1:0] addr);
        return int'(addr - WEIGHT_BASE) / 4;
    endfunction

    function automatic logic [APB_DATA_WIDTH-1:0] sign_extend(input sample_t value);
        return {{(APB_DATA_WIDTH - SAMPLE_WIDTH){value[SAMPLE_WIDTH-1]}}, value};
    endfunction

    function automatic acc_t expected_sum();
        longint total;
        total = 0;
        for (int i = 0; i < TAPS; i++)
        begin
            total += longint'(window[i]) * longint'(model_weights[i]);
        end
        // Hardware adders wrap, so only the low bits are kept.
        return acc_t'(total);
    endfunction

    // ######################################
    // Reporting
    // ######################################

    task automatic flag_value(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic flag_other(input string msg);
        $display("%s at time %0t", msg, $time);
        error_count++;
    endtask

    // ######################################
    // Per-cycle checks
    // ######################################

    task automatic check_result();
        expected_t head;
        if (pending.size() > 0 && pending[0].due == cycle)
        begin
            head = pending.pop_front();
            if (!result.valid)
            begin
                flag_other("A window was captured but its result never appeared");
            end
            else
            begin
                results_checked++;
                if (result.sum !== head.sum)
                begin
                    flag_value($sformatf("result sum %0d, expected %0d", result.sum, head.sum));
                end
            end
        end
        else if (result.valid)
        begin
            flag_other("A result appeared with no window in flight");
        end
    endtask

    task automatic check_apb();
        logic                      access;
        logic [APB_DATA_WIDTH-1:0] want_data;
        access = apb_req.psel && apb_req.penable;
        if (apb_rsp.pready !== 1'b1)
        begin
            flag_value("pready is not high");
        end
        if (apb_rsp.pslverr !== (access && !addr_legal(apb_req.paddr)))
        begin
            flag_value($sformatf("pslverr %b at address %h", apb_rsp.pslverr, apb_req.paddr));
        end
        if (access && !apb_req.pwrite)
        begin
            want_data = '0;
            if (addr_legal(apb_req.paddr))
            begin
                want_data = sign_extend(model_weights[tap_index(apb_req.paddr)]);
            end
            if (apb_rsp.prdata !== want_data)
            begin
                flag_value($sformatf("read %h from address %h, expected %h",
                                     apb_rsp.prdata, apb_req.paddr, want_data));
            end
        end
    endtask

    task automatic record_window();
        expected_t entry;
        entry.due = cycle + LATENCY;
        entry.sum = expected_sum();
        pending.push_back(entry);
    endtask

    task automatic apply_write();
        if (apb_req.psel && apb_req.penable && apb_req.pwrite && addr_legal(apb_req.paddr))
        begin
            model_weights[tap_index(apb_req.paddr)] = apb_req.pwdata[SAMPLE_WIDTH-1:0];
        end
    endtask

    // Inputs change just after the rising edge, so the falling edge sees
    // what the next rising edge will capture.
    always @(negedge clk)
    begin
        if (reset)
        begin
            cycle = 0;
            pending.delete();
            for (int i = 0; i < TAPS; i++)
            begin
                model_weights[i] = '0;
            end
            if (result.valid !== 1'b0)
            begin
                flag_other("result.valid is high during reset");
            end
        end
        else
        begin
            cycle++;
            check_result();
            check_apb();
            // The sum uses the weights from before any write completing at the capture edge.
            if (window_valid)
            begin
                record_window();
            end
            apply_write();
        end
    end

endmodule

// ==== test/conv_window_engine_tb.sv ====
`timescale 1ns/1ps

module conv_window_engine_tb;

    import apb_pkg::*;
    import conv_pkg::*;

    localparam int KERNEL_SIZE   = 5;
    localparam int TAPS          = KERNEL_SIZE * KERNEL_SIZE;
    localparam int LATENCY       = 1 + $clog2(TAPS);
    localparam int BURST_CYCLES  = 100;
    localparam int GAPPED_CYCLES = 300;
    localparam int WINDOW_CYCLES = BURST_CYCLES + GAPPED_CYCLES;
    localparam int LIVE_WRITES   = 4;
    localparam int BAD_ACCESSES  = 6;
    localparam int APB_TRANSFERS = 3 * TAPS + BAD_ACCESSES + LIVE_WRITES;
    localparam int CYCLE_LIMIT   = 2 * (2 * APB_TRANSFERS + WINDOW_CYCLES) + 100;

    logic         clk;
    logic         reset;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic         window_valid;
    sample_t      window [TAPS];
    conv_result_t result;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          windows_sent;
    int          checker_errors;
    int          results_checked;

    conv_window_engine #(
        .KERNEL_SIZE (KERNEL_SIZE)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .window_valid (window_valid),
        .window       (window),
        .result       (result)
    );

    conv_result_checker #(
        .TAPS (TAPS)
    ) u_checker (
        .clk             (clk),
        .reset           (reset),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .window_valid    (window_valid),
        .window          (window),
        .result          (result),
        .error_count     (checker_errors),
        .results_checked (results_checked)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    // ########################################
    // Random source
    // ########################################

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // ########################################
    // Drivers
    // ########################################

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_transfer(input logic                      write_op,
                                input logic [APB_ADDR_WIDTH-1:0] addr,
                                input logic [APB_DATA_WIDTH-1:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write_op, paddr: addr, pwdata: data};
        next_cycle();
        apb_req.penable = 1'b1;
        next_cycle();
        apb_req = '0;
    endtask

    task automatic drive_window(input logic valid);
        for (int i = 0; i < TAPS; i++)
        begin
            window[i] = sample_t'(take_bits(SAMPLE_WIDTH));
        end
        window_valid = valid;
        if (valid)
        begin
            windows_sent++;
        end
    endtask

    task automatic stream_windows();
        for (int c = 0; c < WINDOW_CYCLES; c++)
        begin
            if (c < BURST_CYCLES)
            begin
                drive_window(1'b1);
            end
            else
            begin
                drive_window(take_bits(2) != 32'd0);
            end
            next_cycle();
        end
        window_valid = 1'b0;
    endtask

    // Writes land while windows are still in the pipeline.
    task automatic live_weight_writes();
        int tap;
        repeat (BURST_CYCLES) next_cycle();
        for (int n = 0; n < LIVE_WRITES; n++)
        begin
            repeat (20 + take_bits(5)) next_cycle();
            tap = take_bits(5) % TAPS;
            apb_transfer(1'b1, WEIGHT_BASE + APB_ADDR_WIDTH'(4 * tap), take_bits(32));
        end
    endtask

    task automatic finish_run();
        int run_errors;
        run_errors = 0;
        if (results_checked != windows_sent)
        begin
            $display("%0d windows were sent but %0d results were checked",
                     windows_sent, results_checked);
            run_errors++;
        end
        $display("Errors: %0d from the checker, %0d from the run; %0d results checked",
                 checker_errors, run_errors, results_checked);
        if (checker_errors == 0 && run_errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // ########################################
    // Test sequence
    // ########################################

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        apb_req      = '0;
        window_valid = 1'b0;
        for (int i = 0; i < TAPS; i++)
        begin
            window[i] = '0;
        end
        lfsr_state   = 32'h13a1;
        cycle_count  = 0;
        windows_sent = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Every weight comes out of reset as zero.
        for (int i = 0; i < TAPS; i++)
        begin
            apb_transfer(1'b0, WEIGHT_BASE + APB_ADDR_WIDTH'(4 * i), '0);
        end
        for (int i = 0; i < TAPS; i++)
        begin
            apb_transfer(1'b1, WEIGHT_BASE + APB_ADDR_WIDTH'(4 * i), take_bits(32));
        end

        // Misaligned and out-of-range accesses.
        apb_transfer(1'b1, 12'h002, take_bits(32));
        apb_transfer(1'b0, 12'h002, '0);
        apb_transfer(1'b1, WEIGHT_BASE + APB_ADDR_WIDTH'(4 * TAPS), take_bits(32));
        apb_transfer(1'b0, WEIGHT_BASE + APB_ADDR_WIDTH'(4 * TAPS), '0);
        apb_transfer(1'b1, 12'hffc, take_bits(32));
        apb_transfer(1'b0, 12'h041, '0);

        for (int i = 0; i < TAPS; i++)
        begin
            apb_transfer(1'b0, WEIGHT_BASE + APB_ADDR_WIDTH'(4 * i), '0);
        end

        fork
            stream_windows();
            live_weight_writes();
        join

        repeat (LATENCY + 4) next_cycle();
        finish_run();
    end

endmodule

// ==== sim.f ====
source/conv_pkg.sv
source/apb_pkg.sv
source/conv_weight_regs.sv
source/conv_product_stage.sv
source/conv_adder_tree.sv
source/conv_window_engine.sv
test/conv_result_checker.sv
test/conv_window_engine_tb.sv

// ==== Makefile ====
TOP := conv_window_engine_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f sim.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
